// File: files.f
+incdir+hw
hw/ql_bus_pkg.sv
hw/bus_clock_enables.sv
hw/reset_sequencer.sv
hw/bus_controller.sv
hw/read_data_mux.sv
hw/ql_bus_glue.sv
sim/ql_bus_glue_assertions.sv
sim/tb_ql_bus_glue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the QL bus glue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f files.f \
	--top-module tb_ql_bus_glue -o sim_ql_bus_glue

# The simulation may stop with an error status, the log decides
./obj_dir/sim_ql_bus_glue > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: sim/tb_ql_bus_glue.sv
/*
 * Testbench of the QL bus glue
 *  - clock, reset, bus enable and reset stretch measurement
 *  - random and directed bus cycles for all RAM sizes
 *  - reference decode function, comparing process, watchdog
 */
`timescale 1ns/100ps
`include "ql_consts.svh"

module tb_ql_bus_glue import ql_bus_pkg::*; ();

	localparam int N_RAND = 400;	// Random cycles per RAM size
	localparam int TEST_CYCLES = 4 * 1500 + 4 * (N_RAND + 300) + 500;

	typedef struct packed {
		logic [15:0] din;
		logic        dtack;
		io_sel_t     sel;
		logic        oe;
		logic        we;
		logic [23:0] req_addr;	// SDRAM word address
		logic [15:0] req_data;
		logic [1:0]  req_be;	// uds, lds
		logic        vram_we;
	} expect_t;

	logic clk_sys, reset, sdram_dtack, qlsd_dtack;
	cpu_speed_e cpu_speed;
	ram_cfg_e ram_cfg_req;
	cpu_bus_t cpu_bus;
	rd_sources_t rd_sources;
	logic ce_bus_p, ce_bus_n, ce_refresh, cpu_reset, cpu_dtack, vram_we;
	logic [15:0] cpu_din;
	logic [1:0] vram_be;
	logic [7:0] mc_stat;
	sdram_req_t sdram_req;
	io_sel_t io_sel;

	integer seed;
	int errors;
	ram_cfg_e model_cfg;	// RAM size the DUT latched
	logic model_shadow;	// Model of the GoldCard shadow flag
	expect_t exp_q;
	logic chk_en, chk_din;

	ql_bus_glue u_ql_bus_glue (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;	// 40 ns period
	end

	// ============================================================
	// Reference model
	// ============================================================

	function automatic expect_t ref_decode(cpu_bus_t b, ram_cfg_e cfg, logic shadow,
		logic sd_dt, logic qs_dt);
		logic [23:0] a;
		logic gc, rd, wr, rom, ext, os, io, qimi, zx, ram, boot, oscopy, qen, qsel, qdat;
		rd_src_e src;
		expect_t e;
		gc = (cfg == RAM_4096K);
		case (cfg)
		RAM_128K: a = b.addr & 24'h03FFFF;
		RAM_640K, RAM_896K: a = b.addr & 24'h0FFFFF;
		default: a = b.addr & 24'h7FFFFF;
		endcase
		rd = b.as && b.rw && (b.uds || b.lds);
		wr = b.as && !b.rw && (b.uds || b.lds);
		rom = (a < 24'h010000);
		ext = rom && (a >= 24'h00C000);
		os = rom && !ext;
		io = (a >= 24'h018000) && (a <= 24'h01BFFF);
		qimi = io && (a[13:8] == 6'h3F);
		zx = io && !qimi && !a[6];
		ram = (a >= 24'h020000 && a <= 24'h03FFFF) ||
			(cfg == RAM_640K && a >= 24'h040000 && a <= 24'h0BFFFF) ||
			(cfg == RAM_896K && a >= 24'h040000 && a <= 24'h0FFFFF) ||
			(gc && a >= 24'h040000 && a <= 24'h3FFFFF) ||
			(gc && a >= 24'h010000 && a <= 24'h017FFF) ||
			(gc && a >= 24'h01C100 && a <= 24'h01FFFF);
		boot = gc && (a >= 24'h040000) && (a <= 24'h04FFFF);
		oscopy = gc && (a >= 24'h400000) && (a <= 24'h40FFFF);
		qen = (!gc || shadow) && rom && rd;	// QL-SD lives in ROM space
		qsel = qen && (a >= 24'h00FEE0);
		qdat = qen && (a == 24'(`QL_QLSD_DATA_REG));
		if (io)
			src = qimi ? SRC_IO_QIMI : (zx ? SRC_IO_ZX : SRC_IO_NONE);
		else if (!gc)
			src = qdat ? SRC_QLSD : rom ? SRC_QL_ROM : ram ? SRC_SDRAM : SRC_FF;
		else if (!shadow)
			src = (rom || boot) ? SRC_GC_ROM : oscopy ? SRC_QL_ROM :
				ram ? SRC_SDRAM : SRC_FF;
		else
			src = os ? SRC_SDRAM : qdat ? SRC_QLSD : (ext || oscopy) ? SRC_QL_ROM :
				ram ? SRC_SDRAM : SRC_FF;
		case (src)
		SRC_IO_ZX:   e.din = 16'h4444;
		SRC_IO_QIMI: e.din = 16'h5555;
		SRC_IO_NONE: e.din = 16'h0000;
		SRC_QL_ROM:  e.din = 16'h1111;
		SRC_GC_ROM:  e.din = 16'h2222;
		SRC_SDRAM:   e.din = 16'h3333;
		SRC_QLSD:    e.din = 16'h6666;
		default:     e.din = 16'hFFFF;
		endcase
		e.oe = rd && (ram || (os && shadow));
		e.we = wr && (ram || (os && !shadow));
		e.dtack = qsel ? qs_dt : ((e.oe || e.we) ? sd_dt : 1'b1);
		e.sel.zx8302_sel = (rd || wr) && zx;
		e.sel.qimi_sel = (rd || wr) && qimi;
		e.sel.qlsd_sel = qsel;
		e.req_addr = a >> 1;	// Byte address to word address
		e.req_data = b.wdata;
		e.req_be = {b.uds, b.lds};
		e.vram_we = wr && (a >= 24'h020000) && (a <= 24'h02FFFF);
		return e;
	endfunction

	// GoldCard register write, upper byte only
	function automatic logic next_shadow(cpu_bus_t b, ram_cfg_e cfg, logic shadow);
		logic [23:0] a;
		a = b.addr & 24'h7FFFFF;
		if (cfg == RAM_4096K && b.as && !b.rw && b.uds && !b.lds &&
			a[23:8] == 16'h01C0) begin
			if (a[7:0] == `QL_GC_SHADOW_ON)
				return 1'b1;
			if (a[7:0] == `QL_GC_SHADOW_OFF)
				return 1'b0;
		end
		return shadow;
	endfunction

	function automatic cpu_bus_t make_bus(logic [23:0] addr, logic rw, logic uds,
		logic lds, logic [15:0] wdata);
		cpu_bus_t b;
		b.addr = addr;
		b.as = 1'b1;
		b.rw = rw;
		b.uds = uds;
		b.lds = lds;
		b.wdata = wdata;
		return b;
	endfunction

	// ============================================================
	// Checking
	// ============================================================

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1, "check failed");
		end
	endtask

	// Compares one cycle after each stimulus, at the stable falling edge
	always @(negedge clk_sys) begin
		if (chk_en) begin
			if (chk_din)
				check_equal("cpu_din", {16'd0, cpu_din}, {16'd0, exp_q.din});
			check_equal("cpu_dtack", {31'd0, cpu_dtack}, {31'd0, exp_q.dtack});
			check_equal("io_sel", {29'd0, io_sel}, {29'd0, exp_q.sel});
			check_equal("sdram oe", {31'd0, sdram_req.oe}, {31'd0, exp_q.oe});
			check_equal("sdram we", {31'd0, sdram_req.we}, {31'd0, exp_q.we});
			check_equal("vram_we", {31'd0, vram_we}, {31'd0, exp_q.vram_we});
			if (exp_q.oe || exp_q.we) begin	// Request fields matter only then
				check_equal("sdram addr", {8'd0, sdram_req.addr},
					{8'd0, exp_q.req_addr});
				check_equal("sdram data", {16'd0, sdram_req.data},
					{16'd0, exp_q.req_data});
				check_equal("sdram strobes", {30'd0, sdram_req.uds, sdram_req.lds},
					{30'd0, exp_q.req_be});
			end
		end
	end

	initial begin
		#(TEST_CYCLES * 40 + 20000);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================

	task automatic drive_cycle(input cpu_bus_t b, input logic sd_dt, input logic qs_dt);
		@(posedge clk_sys);
		cpu_bus <= b;
		sdram_dtack <= sd_dt;
		qlsd_dtack <= qs_dt;
		exp_q <= ref_decode(b, model_cfg, model_shadow, sd_dt, qs_dt);
		chk_en <= 1'b1;
		chk_din <= b.as && b.rw;
		model_shadow = next_shadow(b, model_cfg, model_shadow);
	endtask

	task automatic drive_idle();
		@(posedge clk_sys);
		cpu_bus <= '0;
		sdram_dtack <= 1'b1;
		qlsd_dtack <= 1'b1;
		chk_en <= 1'b0;
	endtask

	// Reset, then count bus pulses until the CPU reset drops
	task automatic do_reset(input cpu_speed_e speed, input ram_cfg_e cfg);
		int pulses;
		int cycles;
		@(posedge clk_sys);
		reset <= 1'b1;
		cpu_speed <= speed;
		ram_cfg_req <= cfg;
		cpu_bus <= '0;
		chk_en <= 1'b0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		pulses = 0;
		cycles = 0;
		@(negedge clk_sys);
		while (cpu_reset) begin
			if (ce_bus_p)
				pulses++;
			cycles++;
			if (cycles > 1000) begin
				$display("CPU reset never released after the system reset");
				$display("Errors found");
				$fatal(1, "reset stuck");
			end
			@(negedge clk_sys);
		end
		check_equal("reset pulses", 32'(pulses), 32'(`QL_RESET_HOLD));
		model_cfg = cfg;
		model_shadow = 1'b0;
		@(posedge clk_sys);
		ram_cfg_req <= ram_cfg_e'(cfg ^ 2'b01);	// Must not reach the decode
	endtask

	task automatic measure_enables(input int n);
		int last_p;
		int last_r;
		last_p = -1;
		last_r = -1;
		for (int cyc = 0; cyc < 1300; cyc++) begin
			@(negedge clk_sys);
			if (ce_bus_p) begin
				if (last_p >= 0)
					check_equal("ce_bus_p spacing", 32'(cyc - last_p), 32'(n));
				last_p = cyc;
			end
			if (ce_bus_n && last_p >= 0)
				check_equal("ce_bus_n offset", 32'(cyc - last_p), 32'(n / 2));
			if (ce_refresh) begin
				if (last_r >= 0)
					check_equal("ce_refresh spacing", 32'(cyc - last_r),
						32'(`QL_DIV_REFRESH));
				last_r = cyc;
			end
		end
	endtask

	task automatic random_cycles(input int count);
		logic [31:0] r;
		logic [31:0] s;
		logic [23:0] a;
		for (int i = 0; i < count; i++) begin
			r = $random(seed);
			s = $random(seed);
			a = r[23:0];
			case (s[2:0])	// Bias towards the busy regions
			3'd0: a = a & 24'h00FFFF;
			3'd1: a = {10'h006, a[13:0]};
			3'd2: a = a & 24'h0FFFFF;
			3'd4: a = {a[23:16], 11'h7F7, a[4:0]};	// QL-SD page, high bits wrap
			3'd5: a = {a[23:16], 16'hFEE4};
			3'd6: a = a & 24'h3FFFFF;
			3'd7: a = {a[23:17], 1'b0, a[15:8], 8'h00} | 24'h01C000;
			default: ;
			endcase
			drive_cycle(make_bus(a, s[3], s[4], s[5], r[31:16]), s[6] | s[7], s[8]);
		end
		drive_idle();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		seed = 4;
		errors = 0;
		reset = 1'b1;
		cpu_speed = SPEED_QL;
		ram_cfg_req = RAM_128K;
		cpu_bus = '0;
		sdram_dtack = 1'b1;
		qlsd_dtack = 1'b1;
		chk_en = 1'b0;
		chk_din = 1'b0;
		exp_q = '0;
		model_cfg = RAM_128K;
		model_shadow = 1'b0;
		rd_sources = {16'h1111, 16'h2222, 16'h3333, 16'h4444, 8'h55, 8'h66};

		do_reset(SPEED_QL, RAM_128K);
		measure_enables(32'(`QL_DIV_BUS_QL));
		do_reset(SPEED_16, RAM_128K);
		measure_enables(32'(`QL_DIV_BUS_16));
		do_reset(SPEED_24, RAM_128K);
		measure_enables(32'(`QL_DIV_BUS_24));
		do_reset(SPEED_FULL, RAM_128K);
		measure_enables(32'(`QL_DIV_BUS_FULL));

		// QL sizes, random
		do_reset(SPEED_FULL, RAM_128K);
		random_cycles(N_RAND);
		do_reset(SPEED_24, RAM_640K);
		random_cycles(N_RAND);
		do_reset(SPEED_16, RAM_896K);
		random_cycles(N_RAND);

		// SDRAM wait holds RAM reads, not I/O reads
		drive_cycle(make_bus(24'h020100, 1'b1, 1'b1, 1'b1, 16'h0), 1'b0, 1'b1);
		@(negedge clk_sys);
		check_equal("RAM read dtack", {31'd0, cpu_dtack}, 32'd0);
		drive_cycle(make_bus(24'h018020, 1'b1, 1'b1, 1'b1, 16'h0), 1'b0, 1'b1);
		@(negedge clk_sys);
		check_equal("I/O read dtack", {31'd0, cpu_dtack}, 32'd1);

		// Display control register, then VRAM
		drive_cycle(make_bus(24'h018063, 1'b0, 1'b0, 1'b1, 16'h00A5), 1'b1, 1'b1);
		drive_idle();
		@(negedge clk_sys);
		check_equal("mc_stat", {24'd0, mc_stat}, 32'h0000_00A5);
		drive_cycle(make_bus(24'h020400, 1'b0, 1'b1, 1'b0, 16'h1234), 1'b1, 1'b1);
		@(negedge clk_sys);
		check_equal("vram_we", {31'd0, vram_we}, 32'd1);
		check_equal("vram_be", {30'd0, vram_be}, 32'd2);
		drive_idle();

		// GoldCard boot mapping, shadow on, shadow off
		do_reset(SPEED_FULL, RAM_4096K);
		drive_cycle(make_bus(24'h000100, 1'b1, 1'b1, 1'b1, 16'h0), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h400100, 1'b1, 1'b1, 1'b1, 16'h0), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h000200, 1'b0, 1'b1, 1'b1, 16'hBEEF), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h01C060, 1'b0, 1'b1, 1'b0, 16'h0), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h000100, 1'b1, 1'b1, 1'b1, 16'h0), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h000200, 1'b0, 1'b1, 1'b1, 16'hBEEF), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h00FEE4, 1'b1, 1'b0, 1'b1, 16'h0), 1'b1, 1'b0);
		drive_cycle(make_bus(24'h00C010, 1'b1, 1'b1, 1'b1, 16'h0), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h01C064, 1'b0, 1'b1, 1'b0, 16'h0), 1'b1, 1'b1);
		drive_cycle(make_bus(24'h000100, 1'b1, 1'b1, 1'b1, 16'h0), 1'b1, 1'b1);
		random_cycles(N_RAND);

		repeat (2) @(posedge clk_sys);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: sim/ql_bus_glue_assertions.sv
/*
 * Bound assertions of the QL bus glue
 *  - bus phases never overlap
 *  - enables quiet during reset
 *  - zero wait acknowledge without SDRAM or QL-SD access
 */
`timescale 1ns/100ps

module ql_bus_glue_assertions import ql_bus_pkg::*; (
	input logic       clk_sys,
	input logic       reset,
	input logic       ce_bus_p,
	input logic       ce_bus_n,
	input logic       ce_refresh,
	input logic       cpu_dtack,
	input sdram_req_t sdram_req,
	input io_sel_t    io_sel
);

	// ============================================================
	// Enables
	// ============================================================

	a_phases: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_bus_p && ce_bus_n))
		else $error("bus phase enables high together");

	// Registered, so quiet one cycle into reset
	a_reset_quiet: assert property (@(posedge clk_sys)
		reset |=> (!ce_bus_p && !ce_bus_n && !ce_refresh))
		else $error("clock enable active during reset");

	// Neither SDRAM nor QL-SD, no wait state
	a_dtack: assert property (@(posedge clk_sys) disable iff (reset)
		(!sdram_req.oe && !sdram_req.we && !io_sel.qlsd_sel) |-> cpu_dtack)
		else $error("cycle without wait source not acknowledged");

endmodule

bind ql_bus_glue ql_bus_glue_assertions u_ql_bus_glue_assertions (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.ce_bus_p   (ce_bus_p),
	.ce_bus_n   (ce_bus_n),
	.ce_refresh (ce_refresh),
	.cpu_dtack  (cpu_dtack),
	.sdram_req  (sdram_req),
	.io_sel     (io_sel)
);

// File: hw/ql_bus_glue.sv
/*
 * QL bus glue top level
 *  - clock enables, reset sequencer, bus controller
 *  - read data and acknowledge mux
 */
`timescale 1ns/100ps

module ql_bus_glue import ql_bus_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  cpu_speed_e  cpu_speed,
	input  ram_cfg_e    ram_cfg_req,
	input  cpu_bus_t    cpu_bus,
	input  rd_sources_t rd_sources,
	input  logic        sdram_dtack,
	input  logic        qlsd_dtack,
	output logic        ce_bus_p,
	output logic        ce_bus_n,
	output logic        ce_refresh,
	output logic        cpu_reset,
	output logic [15:0] cpu_din,
	output logic        cpu_dtack,
	output sdram_req_t  sdram_req,
	output logic        vram_we,
	output logic [1:0]  vram_be,
	output io_sel_t     io_sel,
	output logic [7:0]  mc_stat
);

	ram_cfg_e   ram_cfg;	// Latched RAM size
	rd_src_e    rd_src;
	dtack_src_e dtack_src;

	bus_clock_enables u_bus_clock_enables (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_speed  (cpu_speed),
		.ce_bus_p   (ce_bus_p),
		.ce_bus_n   (ce_bus_n),
		.ce_refresh (ce_refresh)
	);

	reset_sequencer u_reset_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ce_bus_p    (ce_bus_p),
		.ram_cfg_req (ram_cfg_req),
		.cpu_reset   (cpu_reset),
		.ram_cfg     (ram_cfg)
	);

	bus_controller u_bus_controller (
		.clk_sys   (clk_sys),
		.cpu_reset (cpu_reset),
		.ram_cfg   (ram_cfg),
		.cpu_bus   (cpu_bus),
		.sdram_req (sdram_req),
		.vram_we   (vram_we),
		.vram_be   (vram_be),
		.io_sel    (io_sel),
		.mc_stat   (mc_stat),
		.rd_src    (rd_src),
		.dtack_src (dtack_src)
	);

	read_data_mux u_read_data_mux (
		.rd_src      (rd_src),
		.dtack_src   (dtack_src),
		.rd_sources  (rd_sources),
		.sdram_dtack (sdram_dtack),
		.qlsd_dtack  (qlsd_dtack),
		.cpu_din     (cpu_din),
		.cpu_dtack   (cpu_dtack)
	);

endmodule

// File: hw/read_data_mux.sv
/*
 * CPU read data and acknowledge
 *  - picks the read word from the source chosen by the controller
 *  - byte wide sources are copied into both halves
 */
`timescale 1ns/100ps

module read_data_mux import ql_bus_pkg::*; (
	input  rd_src_e     rd_src,
	input  dtack_src_e  dtack_src,
	input  rd_sources_t rd_sources,
	input  logic        sdram_dtack,
	input  logic        qlsd_dtack,
	output logic [15:0] cpu_din,
	output logic        cpu_dtack
);

	// ============================================================
	// Data path
	// ============================================================

	always_comb begin
		case (rd_src)
		SRC_IO_ZX:   cpu_din = rd_sources.zx8302;
		SRC_IO_QIMI: cpu_din = {rd_sources.qimi, rd_sources.qimi};	// 8-bit device
		SRC_IO_NONE: cpu_din = 16'h0000;	// Empty I/O reads zero
		SRC_QL_ROM:  cpu_din = rd_sources.ql_rom;
		SRC_GC_ROM:  cpu_din = rd_sources.gc_rom;
		SRC_SDRAM:   cpu_din = rd_sources.sdram;
		SRC_QLSD:    cpu_din = {rd_sources.qlsd, rd_sources.qlsd};
		SRC_FF:      cpu_din = 16'hFFFF;	// Nothing there
		endcase
	end

	// ============================================================
	// Acknowledge
	// ============================================================

	// Slow sources hold the cycle by keeping dtack low
	always_comb begin
		case (dtack_src)
		DT_SDRAM: cpu_dtack = sdram_dtack;
		DT_QLSD:  cpu_dtack = qlsd_dtack;
		default:  cpu_dtack = 1'b1;	// ROM and I/O, no wait
		endcase
	end

endmodule

// File: hw/bus_controller.sv
/*
 * Bus controller
 *  - address wrap per RAM size, QL and GoldCard memory map decode
 *  - GoldCard ROM shadow flag and display control register
 *  - SDRAM request, VRAM write strobe, peripheral selects
 *  - read data and acknowledge source selection
 */
`timescale 1ns/100ps
`include "ql_consts.svh"

module bus_controller import ql_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       cpu_reset,
	input  ram_cfg_e   ram_cfg,
	input  cpu_bus_t   cpu_bus,
	output sdram_req_t sdram_req,
	output logic       vram_we,
	output logic [1:0] vram_be,
	output io_sel_t    io_sel,
	output logic [7:0] mc_stat,
	output rd_src_e    rd_src,
	output dtack_src_e dtack_src
);

	logic [23:0] addr_mask;
	logic [23:0] addr;	// Masked CPU address
	logic gc_en, cpu_rd, cpu_wr, cpu_io;
	logic ql_io, cpu_bram, cpu_xram, cpu_ram;
	logic cpu_rom, cpu_ext_rom, cpu_os_rom;
	logic gc_io, gc_ram1, gc_ram2, gc_boot_rom, gc_os_rom;
	logic qimi_hit, zx_hit;
	logic qlsd_en, qlsd_reg, qlsd_dat, qlsd_rd, qlsd_sel;
	logic rom_shadow, shadow_rd, shadow_wr;
	logic mc_stat_we, gc_reg_we;
	logic sdram_oe, sdram_we;

	// ============================================================
	// Address wrap and strobes
	// ============================================================

	always_comb begin
		case (ram_cfg)
		RAM_128K: addr_mask = 24'h03FFFF;	// 256 KB
		RAM_640K, RAM_896K: addr_mask = 24'h0FFFFF;	// 1 MB
		default: addr_mask = 24'h7FFFFF;	// 8 MB
		endcase
	end

	assign addr   = cpu_bus.addr & addr_mask;
	assign gc_en  = (ram_cfg == RAM_4096K);
	assign cpu_rd = cpu_bus.as && cpu_bus.rw && (cpu_bus.uds || cpu_bus.lds);
	assign cpu_wr = cpu_bus.as && !cpu_bus.rw && (cpu_bus.uds || cpu_bus.lds);
	assign cpu_io = cpu_rd || cpu_wr;

	// QL regions
	assign ql_io       = (addr[23:14] == 10'h006);	// 18000-1BFFF
	assign cpu_bram    = (addr[23:17] == 7'h01);	// 20000-3FFFF
	assign cpu_rom     = (addr[23:16] == 8'h00);	// 0-FFFF
	assign cpu_ext_rom = (addr[23:14] == 10'h003);	// C000-FFFF
	assign cpu_os_rom  = cpu_rom && !cpu_ext_rom;

	// Extended RAM from 40000 up
	assign cpu_xram =
		(ram_cfg == RAM_640K && addr[23:20] == 4'h0 && ^addr[19:18]) ||
		(ram_cfg == RAM_896K && addr[23:20] == 4'h0 && |addr[19:18]) ||
		(ram_cfg == RAM_4096K && addr[23:22] == 2'b00 && |addr[21:18]);

	// GoldCard spaces
	assign gc_io       = gc_en && (addr[23:8] == 16'h01C0);	// 1C000-1C0FF
	assign gc_ram1     = gc_en && (addr[23:15] == 9'h002);	// 10000-17FFF
	assign gc_ram2     = gc_en && (addr[23:14] == 10'h007) && !gc_io;
	assign gc_boot_rom = gc_en && (addr[23:16] == 8'h04);	// Boot ROM again
	assign gc_os_rom   = gc_en && (addr[23:16] == 8'h40);	// Plain OS ROM

	assign cpu_ram = cpu_bram || cpu_xram || gc_ram1 || gc_ram2;

	// Internal I/O, mouse takes the top page
	assign qimi_hit = ql_io && (addr[13:8] == 6'h3F);
	assign zx_hit   = ql_io && !qimi_hit && !addr[6];

	// QL-SD sits in the ROM area, reads only
	assign qlsd_en  = (!gc_en || rom_shadow) && cpu_rom && cpu_rd;
	assign qlsd_reg = qlsd_en && (addr[15:4] == 12'hFEE || addr[15:4] == 12'hFEF);
	assign qlsd_dat = qlsd_en && (addr[15:8] == 8'hFF);
	assign qlsd_sel = qlsd_reg || qlsd_dat;
	assign qlsd_rd  = qlsd_en && (addr[15:0] == `QL_QLSD_DATA_REG);

	assign io_sel.zx8302_sel = cpu_io && zx_hit;
	assign io_sel.qimi_sel   = cpu_io && qimi_hit;
	assign io_sel.qlsd_sel   = qlsd_sel;

	// ============================================================
	// Registers
	// ============================================================

	// ZX8301 has one write-only register at 18063
	assign mc_stat_we = ql_io && addr[6] && addr[5] && addr[1] && cpu_wr && cpu_bus.lds;
	assign gc_reg_we  = gc_io && cpu_wr && cpu_bus.uds && !cpu_bus.lds;

	always_ff @(posedge clk_sys) begin
		if (cpu_reset) begin
			rom_shadow <= 1'b0;
			mc_stat <= 8'h00;
		end else begin
			if (mc_stat_we)
				mc_stat <= cpu_bus.wdata[7:0];
			if (gc_reg_we) begin
				if (addr[7:0] == `QL_GC_SHADOW_ON)
					rom_shadow <= 1'b1;	// OS ROM now from SDRAM
				else if (addr[7:0] == `QL_GC_SHADOW_OFF)
					rom_shadow <= 1'b0;
			end
		end
	end

	// ============================================================
	// Memory requests and source selection
	// ============================================================

	// Shadow RAM is filled while off, read back once on
	assign shadow_rd = cpu_rd && cpu_os_rom && rom_shadow;
	assign shadow_wr = cpu_wr && cpu_os_rom && !rom_shadow;
	assign sdram_oe  = cpu_rd && (cpu_ram || shadow_rd);
	assign sdram_we  = cpu_wr && (cpu_ram || shadow_wr);

	always_comb begin
		sdram_req.addr = {1'b0, addr[23:1]};	// Word address
		sdram_req.data = cpu_bus.wdata;
		sdram_req.we = sdram_we;
		sdram_req.oe = sdram_oe;
		sdram_req.uds = cpu_bus.uds;
		sdram_req.lds = cpu_bus.lds;
	end

	// VRAM is the 64 KB bank at 20000
	assign vram_we = cpu_wr && (addr[23:16] == 8'h02);
	assign vram_be = {cpu_bus.uds, cpu_bus.lds};

	always_comb begin
		if (ql_io) begin	// I/O is mapped in every mode
			if (qimi_hit)
				rd_src = SRC_IO_QIMI;
			else if (zx_hit)
				rd_src = SRC_IO_ZX;
			else
				rd_src = SRC_IO_NONE;
		end else if (!gc_en) begin	// QL mode
			if (qlsd_rd)
				rd_src = SRC_QLSD;
			else if (cpu_rom)
				rd_src = SRC_QL_ROM;
			else if (cpu_ram)
				rd_src = SRC_SDRAM;
			else
				rd_src = SRC_FF;
		end else if (!rom_shadow) begin	// GoldCard boot mapping
			if (cpu_rom || gc_boot_rom)
				rd_src = SRC_GC_ROM;
			else if (gc_os_rom)
				rd_src = SRC_QL_ROM;
			else if (cpu_ram)
				rd_src = SRC_SDRAM;
			else
				rd_src = SRC_FF;
		end else begin	// GoldCard with shadow on
			if (cpu_os_rom)
				rd_src = SRC_SDRAM;
			else if (qlsd_rd)
				rd_src = SRC_QLSD;
			else if (cpu_ext_rom || gc_os_rom)
				rd_src = SRC_QL_ROM;
			else if (cpu_ram)
				rd_src = SRC_SDRAM;
			else
				rd_src = SRC_FF;
		end
	end

	always_comb begin
		if (qlsd_sel)
			dtack_src = DT_QLSD;
		else if (sdram_oe || sdram_we)
			dtack_src = DT_SDRAM;	// Wait for the controller
		else
			dtack_src = DT_ONE;
	end

endmodule

// File: hw/reset_sequencer.sv
/*
 * Reset sequencer
 *  - CPU reset stretched by a number of bus cycles
 *  - RAM size latch, open only while the CPU is held
 */
`timescale 1ns/100ps
`include "ql_consts.svh"

module reset_sequencer import ql_bus_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     ce_bus_p,
	input  ram_cfg_e ram_cfg_req,
	output logic     cpu_reset,
	output ram_cfg_e ram_cfg
);

	logic [4:0] hold_cnt;	// Bus cycles left in reset

	always_ff @(posedge clk_sys) begin
		if (reset)
			hold_cnt <= `QL_RESET_HOLD;	// Reload while held
		else if (ce_bus_p && hold_cnt != 5'd0)
			hold_cnt <= hold_cnt - 5'd1;
	end

	// Latency scales with CPU speed
	assign cpu_reset = (hold_cnt != 5'd0);

	// RAM size only sampled with the CPU stopped,
	// so the memory map never moves under running code
	always_ff @(posedge clk_sys) begin
		if (cpu_reset)
			ram_cfg <= ram_cfg_req;
	end

endmodule

// File: hw/bus_clock_enables.sv
/*
 * Bus clock enables
 *  - two-phase CPU bus enables, ratio set by the CPU speed
 *  - free-running refresh strobe
 */
`timescale 1ns/100ps
`include "ql_consts.svh"

module bus_clock_enables import ql_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_speed_e cpu_speed,
	output logic       ce_bus_p,
	output logic       ce_bus_n,
	output logic       ce_refresh
);

	logic [3:0] div_bus;	// Bus phase counter
	logic [3:0] div_ratio;	// Period for this speed
	logic [3:0] div_half;	// Where the n phase sits
	logic [9:0] div_ref;	// Refresh counter

	// Ratio lookup, speed only moves while in reset
	always_comb begin
		case (cpu_speed)
		SPEED_QL: div_ratio = `QL_DIV_BUS_QL;
		SPEED_16: div_ratio = `QL_DIV_BUS_16;
		SPEED_24: div_ratio = `QL_DIV_BUS_24;
		default: div_ratio = `QL_DIV_BUS_FULL;
		endcase
		div_half = div_ratio >> 1;	// Integer N/2
	end

	// ============================================================
	// Counters and registered strobes
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_bus <= '0;
			div_ref <= '0;
			ce_bus_p <= 1'b0;
			ce_bus_n <= 1'b0;
			ce_refresh <= 1'b0;
		end else begin
			if (div_bus == div_ratio - 4'd1)
				div_bus <= '0;	// Wrap at the speed ratio
			else
				div_bus <= div_bus + 4'd1;

			if (div_ref == `QL_DIV_REFRESH - 10'd1)
				div_ref <= '0;
			else
				div_ref <= div_ref + 10'd1;

			// One clean pulse per period each
			ce_bus_p <= (div_bus == 4'd0);
			ce_bus_n <= (div_bus == div_half);
			ce_refresh <= (div_ref == 10'd0);
		end
	end

endmodule

// File: hw/ql_bus_pkg.sv
/*
 * Types shared by the bus glue and its testbench
 *  - CPU bus bundle and SDRAM request
 *  - CPU speed and RAM size codes
 *  - read source, acknowledge source and peripheral selects
 */
package ql_bus_pkg;

	// CPU speed, picks the bus divider
	typedef enum logic [1:0] {
		SPEED_QL   = 2'd0,	// Original QL
		SPEED_16   = 2'd1,
		SPEED_24   = 2'd2,
		SPEED_FULL = 2'd3
	} cpu_speed_e;

	// RAM size, 4096K also turns on GoldCard mode
	typedef enum logic [1:0] {
		RAM_128K  = 2'd0,
		RAM_640K  = 2'd1,
		RAM_896K  = 2'd2,
		RAM_4096K = 2'd3
	} ram_cfg_e;

	// Where cpu_din comes from
	typedef enum logic [2:0] {
		SRC_IO_ZX   = 3'd0,	// ZX8302 registers
		SRC_IO_QIMI = 3'd1,	// Mouse interface, byte wide
		SRC_IO_NONE = 3'd2,	// Unused I/O, reads zero
		SRC_QL_ROM  = 3'd3,
		SRC_GC_ROM  = 3'd4,	// GoldCard boot ROM
		SRC_SDRAM   = 3'd5,
		SRC_QLSD    = 3'd6,	// SD bridge, byte wide
		SRC_FF      = 3'd7	// Open bus
	} rd_src_e;

	// Who acknowledges the cycle
	typedef enum logic [1:0] {
		DT_SDRAM = 2'd0,
		DT_QLSD  = 2'd1,
		DT_ONE   = 2'd2	// No wait states
	} dtack_src_e;

	// CPU side of the bus, strobes active high
	typedef struct packed {
		logic [23:0] addr;	// Raw, not yet masked
		logic        as;
		logic        rw;	// High for read
		logic        uds;
		logic        lds;
		logic [15:0] wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic [23:0] addr;	// Word address
		logic [15:0] data;
		logic        we;
		logic        oe;
		logic        uds;
		logic        lds;
	} sdram_req_t;

	typedef struct packed {
		logic [15:0] ql_rom;
		logic [15:0] gc_rom;
		logic [15:0] sdram;
		logic [15:0] zx8302;
		logic [7:0]  qimi;
		logic [7:0]  qlsd;
	} rd_sources_t;

	typedef struct packed {
		logic zx8302_sel;
		logic qimi_sel;
		logic qlsd_sel;
	} io_sel_t;

endpackage

// File: hw/ql_consts.svh
/*
 * Constants of the QL bus glue
 *  - bus clock divider ratios per CPU speed
 *  - refresh divider and reset stretch length
 *  - GoldCard register offsets and the QL-SD data register
 */
`ifndef QL_CONSTS_SVH
`define QL_CONSTS_SVH

// ============================================================
// Clock dividers, 84 MHz system clock
// ============================================================

`define QL_DIV_BUS_QL     4'd11   // 7.64 MHz, original QL timing
`define QL_DIV_BUS_16     4'd5    // 16.8 MHz GoldCard
`define QL_DIV_BUS_24     4'd3    // 28 MHz SuperGoldCard
`define QL_DIV_BUS_FULL   4'd2    // 42 MHz, as fast as the bus goes

// About 131 kHz, SDRAM refresh and RTC tick
`define QL_DIV_REFRESH    10'd640

// ============================================================
// Reset and register map
// ============================================================

// Bus cycles that the CPU stays in reset after the system reset
`define QL_RESET_HOLD     5'd16

// GoldCard I/O page offsets, upper byte writes only
`define QL_GC_SHADOW_ON   8'h60   // glo_rena
`define QL_GC_SHADOW_OFF  8'h64   // glo_rdis

// Only QL-SD register that returns data
`define QL_QLSD_DATA_REG  16'hFEE4

`endif
